//--- design/nird_pkg.sv
package nird_pkg;

  // frame geometry, fixed for this block
  localparam logic [15:0] IMG_COLS = 16'd8;
  localparam logic [15:0] IMG_ROWS = 16'd8;
  localparam logic [2:0]  WIN      = 3'd5;

  // pixels in the patch, so GAIN * pixel >= sum means pixel >= mean
  localparam logic [4:0]  GAIN  = 5'd25;
  localparam int          SUM_W = 13;

  localparam logic [3:0]  QUEUE_DEPTH = 4'd8;

  typedef struct packed {
    logic       sof;
    logic [7:0] data;
  } pixel_t;

  // pix[0] is the oldest row, pix[4] the incoming pixel
  typedef struct packed {
    logic [4:0][7:0] pix;
    logic [2:0]      col;
  } column_t;

  // index k is the sample at angle 45 * k, counter-clockwise from the right
  typedef struct packed {
    logic [7:0][7:0]   r1;
    logic [7:0][7:0]   r2;
    logic [SUM_W-1:0]  sum;
  } ring_t;

  typedef struct packed {
    logic [7:0] ni;
    logic [7:0] rd;
  } pattern_t;

  typedef struct packed {
    logic [3:0] ni;
    logic [3:0] rd;
  } code_t;

endpackage

//--- design/row_line_buffer.sv
`timescale 1ns/1ps

module row_line_buffer import nird_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  pixel_t     pix_i,
  input  logic       pix_valid_i,
  output column_t    col_o,
  output logic       col_valid_o,
  output logic [2:0] row_o
);

  // line_mem[0] is the row above, line_mem[3] four rows up
  logic [7:0] line_mem [4][IMG_COLS];

  logic [2:0] col_cnt;
  logic [2:0] row_cnt;
  logic [2:0] cur_col;
  logic [2:0] cur_row;

  // sof puts the incoming pixel at the frame origin
  assign cur_col = pix_i.sof ? 3'd0 : col_cnt;
  assign cur_row = pix_i.sof ? 3'd0 : row_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= 3'd0;
      row_cnt <= 3'd0;
    end else if (pix_valid_i) begin
      if (cur_col == 3'(IMG_COLS - 16'd1)) begin
        col_cnt <= 3'd0;
        row_cnt <= (cur_row == 3'(IMG_ROWS - 16'd1)) ? 3'd0 : cur_row + 3'd1;
      end else begin
        col_cnt <= cur_col + 3'd1;
        row_cnt <= cur_row;
      end
    end
  end

  // each row memory feeds the next one down the chain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 4; k++) begin
        for (int c = 0; c < IMG_COLS; c++) begin
          line_mem[k][c] <= '0;
        end
      end
    end else if (pix_valid_i) begin
      line_mem[0][cur_col] <= pix_i.data;
      for (int k = 1; k < 4; k++) begin
        line_mem[k][cur_col] <= line_mem[k-1][cur_col];
      end
    end
  end

  assign col_o.pix   = {pix_i.data, line_mem[0][cur_col], line_mem[1][cur_col],
                        line_mem[2][cur_col], line_mem[3][cur_col]};
  assign col_o.col   = cur_col;
  assign col_valid_o = pix_valid_i;
  assign row_o       = cur_row;

endmodule

//--- design/window_5x5.sv
`timescale 1ns/1ps

module window_5x5 import nird_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  column_t    col_i,
  input  logic       col_valid_i,
  input  logic [2:0] row_i,
  output ring_t      ring_o,
  output logic       ring_valid_o,
  output logic       border_o
);

  // four stored columns, cols[0] is the leftmost
  logic [WIN-2:0][WIN-1:0][7:0] cols;
  // full window, win[x][y] with x left to right and y top to bottom
  logic [WIN-1:0][WIN-1:0][7:0] win;
  logic [WIN-2:0][SUM_W-1:0]    col_sum;
  logic [SUM_W-1:0]             part_sum;
  logic [SUM_W-1:0]             new_sum;
  logic [SUM_W-1:0]             patch_sum;
  logic [SUM_W-1:0]             full_sum;
  logic                         interior;
  ring_t                        ring_d;

  assign win = {col_i.pix, cols};

  always_comb begin
    new_sum = '0;
    for (int y = 0; y < WIN; y++) begin
      new_sum = new_sum + SUM_W'(col_i.pix[y]);
    end
  end

  // all 25 pixels added up directly
  always_comb begin
    full_sum = '0;
    for (int x = 0; x < WIN; x++) begin
      for (int y = 0; y < WIN; y++) begin
        full_sum = full_sum + SUM_W'(win[x][y]);
      end
    end
  end

  // part_sum covers the four stored columns
  assign patch_sum = part_sum + new_sum;
  assign interior  = (row_i >= WIN - 3'd1) && (col_i.col >= WIN - 3'd1);

  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      cols <= win[WIN-1:1];
    end
  end

  // the running sum must start consistent with its column sums
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_sum  <= '0;
      part_sum <= '0;
    end else if (col_valid_i) begin
      col_sum  <= {new_sum, col_sum[WIN-2:1]};
      part_sum <= patch_sum - col_sum[0];
    end
  end

  // nearest-pixel rings around the centre win[2][2]
  always_comb begin
    ring_d.r1 = {win[3][3], win[2][3], win[1][3], win[1][2],
                 win[1][1], win[2][1], win[3][1], win[3][2]};
    ring_d.r2 = {win[4][4], win[2][4], win[0][4], win[0][2],
                 win[0][0], win[2][0], win[4][0], win[4][2]};
    ring_d.sum = patch_sum;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ring_valid_o <= 1'b0;
      border_o     <= 1'b0;
    end else begin
      ring_valid_o <= col_valid_i && interior;
      border_o     <= col_valid_i && !interior;
    end
  end

  always_ff @(posedge clk) begin
    if (col_valid_i && interior) begin
      ring_o <= ring_d;
    end
  end

  // running patch sum agrees with the window it describes
  assert property (@(posedge clk) disable iff (!rst_n)
    (col_valid_i && interior) |-> (patch_sum == full_sum));

endmodule

//--- design/nird_bits.sv
`timescale 1ns/1ps

module nird_bits import nird_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  ring_t    ring_i,
  input  logic     ring_valid_i,
  input  logic     border_i,
  output pattern_t pat_o,
  output logic     pat_valid_o,
  output logic     border_o
);

  pattern_t pat_d;

  always_comb begin
    for (int k = 0; k < 8; k++) begin
      // scaled pixel against the patch sum, i.e. pixel against the mean
      pat_d.ni[k] = (SUM_W'(ring_i.r2[k]) * SUM_W'(GAIN)) >= ring_i.sum;
      // outer sample against the inner one on the same ray
      pat_d.rd[k] = ring_i.r2[k] >= ring_i.r1[k];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pat_valid_o <= 1'b0;
      border_o    <= 1'b0;
    end else begin
      pat_valid_o <= ring_valid_i;
      border_o    <= border_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ring_valid_i) begin
      pat_o <= pat_d;
    end
  end

endmodule

//--- design/riu2_mapper.sv
`timescale 1ns/1ps

module riu2_mapper import nird_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  pattern_t pat_i,
  input  logic     pat_valid_i,
  input  logic     border_i,
  output code_t    code_o,
  output logic     code_valid_o,
  output logic     border_o
);

  // uniform patterns map to their count of ones, the rest to 9
  function automatic logic [3:0] riu2(input logic [7:0] p);
    logic [3:0] trans;
    logic [3:0] ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < 8; k++) begin
      trans = trans + 4'(p[k] ^ p[(k + 1) % 8]);
      ones  = ones + 4'(p[k]);
    end
    return (trans <= 4'd2) ? ones : 4'd9;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid_o <= 1'b0;
      border_o     <= 1'b0;
    end else begin
      code_valid_o <= pat_valid_i;
      border_o     <= border_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pat_valid_i) begin
      code_o.ni <= riu2(pat_i.ni);
      code_o.rd <= riu2(pat_i.rd);
    end
  end

  // every code leaves as a defined value
  assert property (@(posedge clk) disable iff (!rst_n)
    code_valid_o |-> !$isunknown(code_o));

endmodule

//--- design/code_credit_queue.sv
`timescale 1ns/1ps

module code_credit_queue import nird_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  code_t code_i,
  input  logic  code_valid_i,
  input  logic  border_i,
  input  logic  out_credit_i,
  output code_t code_o,
  output logic  code_valid_o,
  output logic  in_credit_o
);

  code_t                          mem [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [3:0]                     count;
  logic [7:0]                     sink_cnt;
  logic [3:0]                     init_cnt;
  // credits due to the source but not yet sent
  logic [3:0]                     owed;
  logic [4:0]                     req;
  logic                           init_active;
  logic                           deq;
  logic                           full;

  assign full         = (count == QUEUE_DEPTH);
  assign code_valid_o = (count != '0) && (sink_cnt != '0);
  assign deq          = code_valid_o;
  assign code_o       = mem[rd_ptr];

  // one credit per slot after reset, then one per freed slot
  assign init_active = (init_cnt != QUEUE_DEPTH);
  assign req         = 5'(owed) + 5'(border_i) + 5'(deq) + 5'(init_active);
  assign in_credit_o = (req != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      sink_cnt <= '0;
      init_cnt <= '0;
      owed     <= '0;
    end else begin
      if (code_valid_i) wr_ptr <= wr_ptr + 1'b1;
      if (deq) rd_ptr <= rd_ptr + 1'b1;
      count    <= count + 4'(code_valid_i) - 4'(deq);
      sink_cnt <= sink_cnt + 8'(out_credit_i) - 8'(deq);
      if (init_active) init_cnt <= init_cnt + 4'd1;
      owed     <= 4'(req - 5'(in_credit_o));
    end
  end

  always_ff @(posedge clk) begin
    if (code_valid_i) begin
      mem[wr_ptr] <= code_i;
    end
  end

  // the source only sends pixels it holds credits for
  assert property (@(posedge clk) disable iff (!rst_n) code_valid_i |-> !full);

  assert property (@(posedge clk) disable iff (!rst_n)
    (out_credit_i && !deq) |=> (sink_cnt != '0));

endmodule

//--- design/texture_nird_top.sv
`timescale 1ns/1ps

module texture_nird_top import nird_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  pixel_t pix_i,
  input  logic   pix_valid_i,
  input  logic   out_credit_i,
  output logic   in_credit_o,
  output code_t  code_o,
  output logic   code_valid_o
);

  column_t    col;
  logic       col_valid;
  logic [2:0] row;
  ring_t      ring;
  logic       ring_valid;
  pattern_t   pat;
  logic       pat_valid;
  code_t      code;
  logic       code_valid;
  // border pulse, delayed alongside the data stages
  logic       border_w;
  logic       border_p;
  logic       border_c;

  row_line_buffer u_row_line_buffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .col_o       (col),
    .col_valid_o (col_valid),
    .row_o       (row)
  );

  window_5x5 u_window_5x5 (
    .clk          (clk),
    .rst_n        (rst_n),
    .col_i        (col),
    .col_valid_i  (col_valid),
    .row_i        (row),
    .ring_o       (ring),
    .ring_valid_o (ring_valid),
    .border_o     (border_w)
  );

  nird_bits u_nird_bits (
    .clk          (clk),
    .rst_n        (rst_n),
    .ring_i       (ring),
    .ring_valid_i (ring_valid),
    .border_i     (border_w),
    .pat_o        (pat),
    .pat_valid_o  (pat_valid),
    .border_o     (border_p)
  );

  riu2_mapper u_riu2_mapper (
    .clk          (clk),
    .rst_n        (rst_n),
    .pat_i        (pat),
    .pat_valid_i  (pat_valid),
    .border_i     (border_p),
    .code_o       (code),
    .code_valid_o (code_valid),
    .border_o     (border_c)
  );

  code_credit_queue u_code_credit_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .code_i       (code),
    .code_valid_i (code_valid),
    .border_i     (border_c),
    .out_credit_i (out_credit_i),
    .code_o       (code_o),
    .code_valid_o (code_valid_o),
    .in_credit_o  (in_credit_o)
  );

endmodule

//--- tests/tb_texture_nird.sv
`timescale 1ns/1ps

module tb_texture_nird import nird_pkg::*;;

  localparam int FRAMES       = 2;
  localparam int CODES_FRAME  = 16;
  localparam int WAIT_LIMIT   = 2000;
  localparam int HOLD_CYCLES  = 200;
  localparam int PART_PIXELS  = 3;

  logic   clk;
  logic   rst_n;
  pixel_t pix_i;
  logic   pix_valid_i;
  logic   out_credit_i;
  logic   in_credit_o;
  code_t  code_o;
  logic   code_valid_o;

  logic [7:0] frame_pix [IMG_ROWS * IMG_COLS];
  logic [3:0] exp_ni [CODES_FRAME];
  logic [3:0] exp_rd [CODES_FRAME];

  logic [31:0] lcg_state = 32'h2052a317;
  int errors;
  int credits_rcvd;
  int pixels_sent;
  int border_sent;
  int codes_seen;

  texture_nird_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_i        (pix_i),
    .pix_valid_i  (pix_valid_i),
    .out_credit_i (out_credit_i),
    .in_credit_o  (in_credit_o),
    .code_o       (code_o),
    .code_valid_o (code_valid_o)
  );

  always #5 clk = ~clk;

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task check_value(input int actual, input int expected, input string what);
    if (actual != expected) begin
      errors++;
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task abort_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task load_trace();
    int    fd;
    int    n;
    string line;
    logic [7:0] value;
    logic [3:0] ni;
    logic [3:0] rd;
    fd = $fopen("tests/nird_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file tests/nird_trace.txt");
    end
    // two comment lines describe the columns
    n = $fgets(line, fd);
    n = $fgets(line, fd);
    for (int i = 0; i < IMG_ROWS * IMG_COLS; i++) begin
      n = $fscanf(fd, "%h", value);
      if (n != 1) begin
        abort_run("trace file ended before all pixels were read");
      end
      frame_pix[i] = value;
    end
    for (int i = 0; i < CODES_FRAME; i++) begin
      n = $fscanf(fd, "%h %h", ni, rd);
      if (n != 2) begin
        abort_run("trace file ended before all expected codes were read");
      end
      exp_ni[i] = ni;
      exp_rd[i] = rd;
    end
    $fclose(fd);
  endtask

  // sends the first count pixels of the frame in raster order
  // position is always one time unit after a rising edge
  task send_frame(input int count);
    int gap;
    int waited;
    int r;
    int c;
    for (int i = 0; i < count; i++) begin
      r = i / int'(IMG_COLS);
      c = i % int'(IMG_COLS);
      gap = next_rand() % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      waited = 0;
      while (credits_rcvd <= pixels_sent && waited < WAIT_LIMIT) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (waited >= WAIT_LIMIT) begin
        abort_run("source timed out waiting for an input credit");
      end
      pix_i.sof   = (i == 0);
      pix_i.data  = frame_pix[i];
      pix_valid_i = 1'b1;
      pixels_sent++;
      // window centre off the frame interior gives back its credit
      if (r < WIN - 1 || c < WIN - 1) border_sent++;
      @(posedge clk);
      #1;
      pix_valid_i = 1'b0;
      pix_i.sof   = 1'b0;
    end
  endtask

  task run_sink();
    int granted;
    int waited;
    repeat (HOLD_CYCLES) @(posedge clk);
    #1;
    check_value(codes_seen, 0, "codes seen while sink held back credits");
    granted = 0;
    waited  = 0;
    while (granted < FRAMES * CODES_FRAME && waited < WAIT_LIMIT * 4) begin
      out_credit_i = (next_rand() % 4) == 0;
      if (out_credit_i) granted++;
      @(posedge clk);
      #1;
      waited++;
    end
    out_credit_i = 1'b0;
    if (waited >= WAIT_LIMIT * 4) begin
      abort_run("sink timed out while returning credits");
    end
  endtask

  // credit counting, code checking and the credit bound
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_credit_o) credits_rcvd++;
      if (code_valid_o) begin
        if (codes_seen >= FRAMES * CODES_FRAME) begin
          errors++;
          $display("error at %0t ns: more codes than the frames can produce", $time);
        end else begin
          check_value(code_o.ni, exp_ni[codes_seen % CODES_FRAME], "ni code");
          check_value(code_o.rd, exp_rd[codes_seen % CODES_FRAME], "rd code");
        end
        codes_seen++;
      end
      check_value(credits_rcvd <= int'(QUEUE_DEPTH) + codes_seen + border_sent, 1,
                  "input credits within bound");
    end
  end

  initial begin
    int waited;
    clk          = 1'b0;
    rst_n        = 1'b0;
    pix_i        = '0;
    pix_valid_i  = 1'b0;
    out_credit_i = 1'b0;
    errors       = 0;
    credits_rcvd = 0;
    pixels_sent  = 0;
    border_sent  = 0;
    codes_seen   = 0;
    load_trace();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset credits only, nothing leaves yet
    repeat (20) @(posedge clk);
    #1;
    check_value(credits_rcvd, QUEUE_DEPTH, "input credits after reset");
    check_value(codes_seen, 0, "codes before any pixel");

    fork
      begin
        send_frame(int'(IMG_ROWS * IMG_COLS));
        repeat (30) @(posedge clk);
        #1;
        // a cut-off frame leaves the position counters mid-row
        send_frame(PART_PIXELS);
        repeat (30) @(posedge clk);
        #1;
        send_frame(int'(IMG_ROWS * IMG_COLS));
      end
      run_sink();
    join

    waited = 0;
    while (codes_seen < FRAMES * CODES_FRAME && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (waited >= WAIT_LIMIT) begin
      abort_run("timed out waiting for the queue to drain");
    end
    repeat (10) @(posedge clk);
    #1;
    check_value(codes_seen, FRAMES * CODES_FRAME, "codes in total");
    check_value(credits_rcvd, int'(QUEUE_DEPTH) + codes_seen + border_sent,
                "input credits in total");

    $display("run complete: %0d codes checked, %0d errors", codes_seen, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tests/nird_trace.txt
# 8 rows of 8 hex pixels, raster order
# then 16 lines of expected ni rd codes (hex), raster order of window centres
80 01 02 03 04 05 06 07
10 11 12 13 14 15 16 17
20 21 22 23 24 25 26 27
30 31 32 33 34 35 36 37
40 41 42 43 44 45 46 47
50 51 52 53 54 55 56 57
60 61 62 63 64 65 66 67
70 71 72 73 74 75 76 ff
9 9
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
4 4
3 4

//--- verilog.f
design/nird_pkg.sv
design/row_line_buffer.sv
design/window_5x5.sv
design/nird_bits.sv
design/riu2_mapper.sv
design/code_credit_queue.sv
design/texture_nird_top.sv
tests/tb_texture_nird.sv

//--- Bender.yml
package:
  name: texture_nird

sources:
  - files:
      - design/nird_pkg.sv
      - design/row_line_buffer.sv
      - design/window_5x5.sv
      - design/nird_bits.sv
      - design/riu2_mapper.sv
      - design/code_credit_queue.sv
      - design/texture_nird_top.sv
  - target: test
    files:
      - tests/tb_texture_nird.sv
